/* build.f */
source/kpu_pkg.sv
source/register_file.sv
source/mlu.sv
source/shifter.sv
source/mmu.sv
source/control_logic.sv
source/kpu.sv
bench/kpu_properties.sv
bench/kpu_tb.sv

/* Bender.yml */
package:
  name: kpu

sources:
  - files:
      - source/kpu_pkg.sv
      - source/register_file.sv
      - source/mlu.sv
      - source/shifter.sv
      - source/mmu.sv
      - source/control_logic.sv
      - source/kpu.sv
  - target: test
    files:
      - bench/kpu_properties.sv
      - bench/kpu_tb.sv

/* bench/kpu_tb.sv */
`timescale 1ns/10ps

module kpu_tb import kpu_pkg::*; ();

  localparam int NUM_PROGS      = 8;
  localparam int HALT_ADDR      = 56;
  localparam int MAX_INSTRS     = HALT_ADDR + 1;
  localparam int ADDR_REG       = 20;
  localparam int DATA_BASE      = 128;
  // Reset, then per program a full memory load, the slowest run and the halt watch
  localparam int TIMEOUT_CYCLES = 16 + NUM_PROGS * (MEM_WORDS + MAX_INSTRS * 7 + 20) + 100;

  logic                  clk;
  logic                  rst;
  logic                  run;
  logic                  load_we;
  logic [MEM_ADDR_W-1:0] load_addr;
  word_t                 load_data;
  word_t                 bus;
  logic                  io_strobe;
  logic                  halted;

  logic [31:0] seed = 32'hb20d68da;
  word_t       image [MEM_WORDS];
  word_t       out_q [$];
  int          gen_pc;
  int          cycles;
  opcode_e     alu_ops [5] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
  opcode_e     shift_ops [3] = '{OP_SHL, OP_SHR, OP_SAR};

  kpu u_kpu (
    .clk(clk),
    .rst(rst),
    .run(run),
    .load_we(load_we),
    .load_addr(load_addr),
    .load_data(load_data),
    .bus(bus),
    .io_strobe(io_strobe),
    .halted(halted)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // LCG step with the draw taken from the upper bits
  function automatic int unsigned random_below(int unsigned n);
    seed = seed * 32'd1664525 + 32'd1013904223;
    return (seed >> 8) % n;
  endfunction

  // opcode 5..0, rd 10..6, ra 15..11, immediate or rb from 16 up
  function automatic word_t encode(opcode_e op, int unsigned rd, int unsigned ra,
                                   int unsigned imm);
    return {imm[15:0], ra[4:0], rd[4:0], op};
  endfunction

  function automatic word_t fill_word(int unsigned addr);
    return {~addr[7:0], addr[7:0] ^ 8'h5a, addr[7:0], addr[7:0] + 8'h3c};
  endfunction

  task automatic stop_with_failure();
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic check_word(string name, word_t expected, word_t actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %h, actual %h", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic check_bit(string name, logic expected, logic actual);
    if (actual !== expected) begin
      $display("Fail %s: expected %b, actual %b", name, expected, actual);
      stop_with_failure();
    end
  endtask

  // Words past the halt slot are dropped
  task automatic put(word_t w);
    if (gen_pc < HALT_ADDR) begin
      image[gen_pc] = w;
      gen_pc++;
    end
  endtask

  task automatic put_out(int unsigned r);
    put(encode(OP_OUT, 0, r, 0));
  endtask

  task automatic build_program();
    int unsigned kind;
    int unsigned rd;
    int unsigned ra;
    int unsigned rb;
    int unsigned target;
    for (int a = 0; a < MEM_WORDS; a++) begin
      image[a] = fill_word(a);
    end
    gen_pc = 0;
    for (int r = 1; r < 16; r++) begin
      put(encode(OP_LDI, r, 0, random_below(65536)));
    end
    put(encode(OP_LDI, ADDR_REG, 0, DATA_BASE + random_below(128)));
    while (gen_pc < HALT_ADDR) begin
      kind = random_below(12);
      rd   = 1 + random_below(15);
      ra   = random_below(16);
      rb   = random_below(16);
      case (kind)
        0, 1, 2: begin
          put(encode(alu_ops[random_below(5)], rd, ra, rb));
          put_out(rd);
        end
        3, 4: begin
          put(encode(shift_ops[random_below(3)], rd, ra, rb));
          put_out(rd);
        end
        5: begin
          if (random_below(2) != 0) begin
            put(encode(OP_LDI, ADDR_REG, 0, DATA_BASE + random_below(128)));
          end else begin
            put(encode(OP_LDI, rd, 0, random_below(65536)));
          end
        end
        // Store, then read the same word back
        6: begin
          put(encode(OP_ST, rd, ADDR_REG, 0));
          put(encode(OP_LD, 16 - rd, ADDR_REG, 0));
          put_out(16 - rd);
        end
        7: begin
          put(encode(OP_LD, rd, ADDR_REG, 0));
          put_out(rd);
        end
        8, 9: put_out(ra);
        10: begin
          put(encode(OP_TIME, rd, 0, 0));
          put_out(rd);
        end
        default: begin
          target = gen_pc + 2 + random_below(3);
          if (target > HALT_ADDR) target = HALT_ADDR;
          put(encode(OP_JZ, 0, (random_below(2) != 0) ? 0 : ra, target));
        end
      endcase
    end
    image[HALT_ADDR] = encode(OP_HALT, 0, 0, 0);
  endtask

  // ISA model with the timer at 1 in the first fetch cycle
  task automatic run_model();
    word_t       regs [NUM_REGS];
    word_t       mem [MEM_WORDS];
    word_t       w;
    word_t       a;
    word_t       b;
    logic [31:0] t;
    int          rd;
    int          cyc;
    int          steps;
    bit          done;
    mem = image;
    foreach (regs[i]) regs[i] = '0;
    t     = 32'd1;
    done  = 1'b0;
    steps = 0;
    out_q.delete();
    while (!done && steps < MAX_INSTRS) begin
      w = mem[regs[PC_REG][7:0]];
      regs[PC_REG] = regs[PC_REG] + 1;
      rd  = w[10:6];
      a   = regs[w[15:11]];
      b   = regs[w[20:16]];
      cyc = 3;
      case (opcode_e'(w[5:0]))
        OP_ADD: regs[rd] = a + b;
        OP_SUB: regs[rd] = a - b;
        OP_AND: regs[rd] = a & b;
        OP_OR:  regs[rd] = a | b;
        OP_XOR: regs[rd] = a ^ b;
        OP_SHL: regs[rd] = a << b[4:0];
        OP_SHR: regs[rd] = a >> b[4:0];
        // Vacated top bits take copies of the sign bit
        OP_SAR: regs[rd] = (a >> b[4:0]) | ({32{a[31]}} & ~(32'hffff_ffff >> b[4:0]));
        OP_JZ:  if (a == '0) regs[PC_REG] = {16'h0, w[31:16]};
        OP_LDI: begin
          regs[rd] = {16'h0, w[31:16]};
          cyc = 1;
        end
        OP_LD: begin
          regs[rd] = mem[a[7:0]];
          cyc = 2;
        end
        OP_ST: begin
          mem[a[7:0]] = regs[rd];
          cyc = 2;
        end
        OP_OUT: begin
          out_q.push_back(a);
          cyc = 1;
        end
        // Sampled in the first execute cycle
        OP_TIME: begin
          regs[rd] = t + 4;
          cyc = 1;
        end
        default: begin
          done = 1'b1;
          cyc = 1;
        end
      endcase
      t = t + 4 + cyc;
      steps++;
    end
  endtask

  initial begin
    int strobes;
    rst       = 1'b1;
    run       = 1'b0;
    load_we   = 1'b0;
    load_addr = '0;
    load_data = '0;
    repeat (16) @(posedge clk);
    for (int p = 0; p < NUM_PROGS; p++) begin
      build_program();
      run_model();
      rst <= 1'b1;
      run <= 1'b0;
      for (int a = 0; a < MEM_WORDS; a++) begin
        load_we   <= 1'b1;
        load_addr <= a[MEM_ADDR_W-1:0];
        load_data <= image[a];
        @(posedge clk);
      end
      load_we <= 1'b0;
      rst     <= 1'b0;
      run     <= 1'b1;
      @(negedge clk);
      check_bit($sformatf("program %0d halted after reset", p), 1'b0, halted);
      strobes = 0;
      do begin
        @(negedge clk);
        if (io_strobe) begin
          if (out_q.size() == 0) begin
            $display("Program %0d gave more io_strobe pulses than the model", p);
            stop_with_failure();
          end
          check_word($sformatf("program %0d OUT %0d", p, strobes), out_q.pop_front(), bus);
          strobes++;
        end
      end while (!halted);
      repeat (8) begin
        @(negedge clk);
        check_bit($sformatf("program %0d halted held", p), 1'b1, halted);
        check_bit($sformatf("program %0d io_strobe after halt", p), 1'b0, io_strobe);
      end
      if (out_q.size() != 0) begin
        $display("Program %0d halted with %0d OUT values still expected", p, out_q.size());
        stop_with_failure();
      end
      @(posedge clk);
    end
    $display("NO ERRORS");
    $finish;
  end

  initial begin
    cycles = 0;
    forever begin
      @(posedge clk);
      cycles++;
      if (cycles >= TIMEOUT_CYCLES) begin
        $display("Timeout: programs did not finish within %0d cycles", TIMEOUT_CYCLES);
        stop_with_failure();
      end
    end
  end

endmodule

/* bench/kpu_properties.sv */
`timescale 1ns/10ps

module kpu_properties import kpu_pkg::*; (
  input logic     clk,
  input logic     rst,
  input logic     run,
  input logic     load_we,
  input logic     io_strobe,
  input logic     halted,
  input bus_src_e bus_src,
  input bus_dst_e bus_dst
);

  // OUT puts register ra on the bus
  strobe_from_reg: assert property (@(posedge clk) io_strobe |-> bus_src == SRC_REG)
    else $error("io_strobe while the bus is not driven by the register file");

  no_load_when_halted: assert property (@(posedge clk) halted |-> bus_dst == DST_NONE)
    else $error("bus sink selected while halted");

  // Microstate is idle one edge after rst
  no_load_after_rst: assert property (@(posedge clk) rst |=> bus_dst == DST_NONE)
    else $error("bus sink selected during reset");

  load_port_stopped: assert property (@(posedge clk) !(load_we && run))
    else $error("load_we high while run is high");

  halted_sticky: assert property (@(posedge clk) $fell(halted) |-> $past(rst))
    else $error("halted fell without rst");

endmodule

bind kpu kpu_properties u_kpu_properties (
  .clk(clk),
  .rst(rst),
  .run(run),
  .load_we(load_we),
  .io_strobe(io_strobe),
  .halted(halted),
  .bus_src(bus_src),
  .bus_dst(bus_dst)
);

/* source/kpu.sv */
`timescale 1ns/10ps

module kpu import kpu_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  run,
  input  logic                  load_we,
  input  logic [MEM_ADDR_W-1:0] load_addr,
  input  word_t                 load_data,
  output word_t                 bus,
  output logic                  io_strobe,
  output logic                  halted
);

  bus_src_e              bus_src;
  bus_dst_e              bus_dst;
  reg_sel_e              reg_sel;
  logic [CTRL_DATA_W-1:0] ctrl_data;
  mlu_op_e               mlu_op;
  logic                  mlu_carry_in;
  shift_op_e             shift_op;
  logic                  mlu_zero;
  word_t                 tmp0, tmp1, opword, timer;
  word_t                 reg_rdata, mlu_result, shifter_result, mem_rdata;
  reg_idx_t              src0, src1, src2;
  logic [IMM_W-1:0]      imm;

  assign src0 = opword[SRC0_LSB +: REG_IDX_W];
  assign src1 = opword[SRC1_LSB +: REG_IDX_W];
  assign src2 = opword[SRC2_LSB +: REG_IDX_W];
  assign imm  = opword[IMM_LSB +: IMM_W];

  // Scratch registers, opword and the timer
  always_ff @(posedge clk) begin
    if (rst) begin
      tmp0   <= '0;
      tmp1   <= '0;
      opword <= '0;
      timer  <= '0;
    end else begin
      timer <= timer + 1'b1;
      if (bus_dst == DST_TMP0) tmp0 <= bus;
      if (bus_dst == DST_TMP1) tmp1 <= bus;
      if (bus_dst == DST_OPWORD) opword <= bus;
    end
  end

  // Out plane selects exactly one driver
  always_comb begin
    case (bus_src)
      SRC_REG:       bus = reg_rdata;
      SRC_TMP0:      bus = tmp0;
      SRC_TMP1:      bus = tmp1;
      SRC_MLU:       bus = mlu_result;
      SRC_SHIFTER:   bus = shifter_result;
      SRC_TIMER:     bus = timer;
      SRC_MEM:       bus = mem_rdata;
      SRC_CTRL_DATA: bus = {{(WORD_W-CTRL_DATA_W){1'b0}}, ctrl_data};
      SRC_IMM:       bus = {{(WORD_W-IMM_W){1'b0}}, imm};
      default:       bus = '0;
    endcase
  end

  register_file u_register_file (
    .clk(clk), .rst(rst), .reg_sel(reg_sel), .src0(src0), .src1(src1), .src2(src2),
    .ctrl_idx(ctrl_data[REG_IDX_W-1:0]), .we(bus_dst == DST_REG), .wdata(bus),
    .rdata(reg_rdata)
  );

  mlu u_mlu (
    .a(tmp0), .b(tmp1), .op(mlu_op), .carry_in(mlu_carry_in), .result(mlu_result),
    .zero(mlu_zero), .carry(), .negative()
  );

  shifter u_shifter (
    .value(tmp0), .amount(tmp1[4:0]), .op(shift_op), .result(shifter_result)
  );

  // External loads only while the core is stopped
  mmu u_mmu (
    .clk(clk), .addr(tmp0[MEM_ADDR_W-1:0]), .we(bus_dst == DST_MEM), .wdata(bus),
    .rdata(mem_rdata), .load_we(load_we && !run), .load_addr(load_addr),
    .load_data(load_data)
  );

  control_logic u_control_logic (
    .clk(clk), .rst(rst), .run(run), .opcode(opcode_e'(opword[OPCODE_LSB +: OPCODE_W])),
    .mlu_zero(mlu_zero), .bus_src(bus_src), .bus_dst(bus_dst), .reg_sel(reg_sel),
    .ctrl_data(ctrl_data), .mlu_op(mlu_op), .mlu_carry_in(mlu_carry_in),
    .shift_op(shift_op), .io_strobe(io_strobe), .halted(halted)
  );

endmodule

/* source/control_logic.sv */
`timescale 1ns/10ps

module control_logic import kpu_pkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic                   run,
  input  opcode_e                opcode,
  input  logic                   mlu_zero,
  output bus_src_e               bus_src,
  output bus_dst_e               bus_dst,
  output reg_sel_e               reg_sel,
  output logic [CTRL_DATA_W-1:0] ctrl_data,
  output mlu_op_e                mlu_op,
  output logic                   mlu_carry_in,
  output shift_op_e              shift_op,
  output logic                   io_strobe,
  output logic                   halted
);

  typedef enum logic [3:0] {
    ST_IDLE, ST_FETCH0, ST_FETCH1, ST_FETCH2, ST_FETCH3,
    ST_EXEC0, ST_EXEC1, ST_EXEC2, ST_HALTED
  } state_e;

  state_e    state;
  state_e    state_next;
  state_e    exec_last;
  logic      halt_op;
  mlu_op_e   alu_op;
  logic      alu_carry;
  shift_op_e alu_shift;

  // Per-opcode execute length and function selects
  always_comb begin
    exec_last = ST_EXEC0;
    halt_op   = 1'b0;
    alu_op    = MLU_ADD;
    alu_carry = 1'b0;
    alu_shift = SH_LEFT;
    case (opcode)
      OP_ADD: exec_last = ST_EXEC2;
      OP_SUB: begin
        exec_last = ST_EXEC2;
        alu_op    = MLU_SUB;
        alu_carry = 1'b1;
      end
      OP_AND: begin
        exec_last = ST_EXEC2;
        alu_op    = MLU_AND;
      end
      OP_OR: begin
        exec_last = ST_EXEC2;
        alu_op    = MLU_OR;
      end
      OP_XOR: begin
        exec_last = ST_EXEC2;
        alu_op    = MLU_XOR;
      end
      OP_SHL, OP_JZ: exec_last = ST_EXEC2;
      OP_SHR: begin
        exec_last = ST_EXEC2;
        alu_shift = SH_RIGHT;
      end
      OP_SAR: begin
        exec_last = ST_EXEC2;
        alu_shift = SH_ARITH;
      end
      OP_LD, OP_ST: exec_last = ST_EXEC1;
      OP_LDI, OP_OUT, OP_TIME: exec_last = ST_EXEC0;
      default: halt_op = 1'b1;
    endcase
  end

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE:   if (run) state_next = ST_FETCH0;
      ST_FETCH0: state_next = ST_FETCH1;
      ST_FETCH1: state_next = ST_FETCH2;
      ST_FETCH2: state_next = ST_FETCH3;
      ST_FETCH3: state_next = ST_EXEC0;
      ST_EXEC0, ST_EXEC1, ST_EXEC2: begin
        if (state == exec_last) begin
          state_next = halt_op ? ST_HALTED : ST_FETCH0;
        end else begin
          state_next = state_e'(state + 1'b1);
        end
      end
      default: state_next = ST_HALTED;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else begin
      state <= state_next;
    end
  end

  // One out-plane and one in-plane choice per microstep
  always_comb begin
    bus_src      = SRC_NONE;
    bus_dst      = DST_NONE;
    reg_sel      = SEL_SRC0;
    ctrl_data    = '0;
    mlu_op       = MLU_ADD;
    mlu_carry_in = 1'b0;
    shift_op     = SH_LEFT;
    io_strobe    = 1'b0;
    case (state)
      // PC to tmp0, fetch word, then PC + 1 back into r31
      ST_FETCH0: begin
        bus_src   = SRC_REG;
        reg_sel   = SEL_CTRL;
        ctrl_data = CTRL_DATA_W'(PC_REG);
        bus_dst   = DST_TMP0;
      end
      ST_FETCH1: begin
        bus_src = SRC_MEM;
        bus_dst = DST_OPWORD;
      end
      ST_FETCH2: begin
        bus_src   = SRC_CTRL_DATA;
        ctrl_data = CTRL_DATA_W'(1);
        bus_dst   = DST_TMP1;
      end
      ST_FETCH3: begin
        bus_src   = SRC_MLU;
        bus_dst   = DST_REG;
        reg_sel   = SEL_CTRL;
        ctrl_data = CTRL_DATA_W'(PC_REG);
      end
      ST_EXEC0: begin
        case (opcode)
          OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR, OP_SAR,
          OP_LD, OP_ST, OP_JZ: begin
            bus_src = SRC_REG;
            reg_sel = SEL_SRC1;
            bus_dst = DST_TMP0;
          end
          OP_LDI: begin
            bus_src = SRC_IMM;
            bus_dst = DST_REG;
          end
          OP_OUT: begin
            bus_src   = SRC_REG;
            reg_sel   = SEL_SRC1;
            io_strobe = 1'b1;
          end
          OP_TIME: begin
            bus_src = SRC_TIMER;
            bus_dst = DST_REG;
          end
          default: ;
        endcase
      end
      ST_EXEC1: begin
        case (opcode)
          OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SHL, OP_SHR, OP_SAR: begin
            bus_src = SRC_REG;
            reg_sel = SEL_SRC2;
            bus_dst = DST_TMP1;
          end
          OP_LD: begin
            bus_src = SRC_MEM;
            bus_dst = DST_REG;
          end
          // Store writes rd to the word at ra
          OP_ST: begin
            bus_src = SRC_REG;
            bus_dst = DST_MEM;
          end
          OP_JZ: begin
            bus_src = SRC_CTRL_DATA;
            bus_dst = DST_TMP1;
          end
          default: ;
        endcase
      end
      ST_EXEC2: begin
        mlu_op       = alu_op;
        mlu_carry_in = alu_carry;
        shift_op     = alu_shift;
        case (opcode)
          OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR: begin
            bus_src = SRC_MLU;
            bus_dst = DST_REG;
          end
          OP_SHL, OP_SHR, OP_SAR: begin
            bus_src = SRC_SHIFTER;
            bus_dst = DST_REG;
          end
          // ra + 0 through the MLU sets the zero flag
          OP_JZ: begin
            if (mlu_zero) begin
              bus_src   = SRC_IMM;
              bus_dst   = DST_REG;
              reg_sel   = SEL_CTRL;
              ctrl_data = CTRL_DATA_W'(PC_REG);
            end
          end
          default: ;
        endcase
      end
      default: ;
    endcase
  end

  assign halted = (state == ST_HALTED);

endmodule

/* source/mmu.sv */
`timescale 1ns/10ps

module mmu import kpu_pkg::*; (
  input  logic                  clk,
  input  logic [MEM_ADDR_W-1:0] addr,
  input  logic                  we,
  input  word_t                 wdata,
  output word_t                 rdata,
  input  logic                  load_we,
  input  logic [MEM_ADDR_W-1:0] load_addr,
  input  word_t                 load_data
);

  word_t mem [MEM_WORDS];

  // Asynchronous read, the bus sees it in the same cycle
  assign rdata = mem[addr];

  // Load port has priority over bus stores
  always_ff @(posedge clk) begin
    if (load_we) begin
      mem[load_addr] <= load_data;
    end else if (we) begin
      mem[addr] <= wdata;
    end
  end

endmodule

/* source/shifter.sv */
`timescale 1ns/10ps

module shifter import kpu_pkg::*; (
  input  word_t       value,
  input  logic [4:0]  amount,
  input  shift_op_e   op,
  output word_t       result
);

  always_comb begin
    case (op)
      SH_LEFT:  result = value << amount;
      SH_RIGHT: result = value >> amount;
      // Sign bit fills from the top
      SH_ARITH: result = word_t'($signed(value) >>> amount);
      default:  result = value;
    endcase
  end

endmodule

/* source/mlu.sv */
`timescale 1ns/10ps

module mlu import kpu_pkg::*; (
  input  word_t   a,
  input  word_t   b,
  input  mlu_op_e op,
  input  logic    carry_in,
  output word_t   result,
  output logic    zero,
  output logic    carry,
  output logic    negative
);

  word_t             b_eff;
  logic [WORD_W:0]   sum;

  // Subtract is a + ~b + 1, with the 1 arriving on carry_in
  assign b_eff = (op == MLU_SUB) ? ~b : b;
  assign sum   = {1'b0, a} + {1'b0, b_eff} + {{WORD_W{1'b0}}, carry_in};

  always_comb begin
    carry = 1'b0;
    case (op)
      MLU_ADD, MLU_SUB: begin
        result = sum[WORD_W-1:0];
        carry  = sum[WORD_W];
      end
      MLU_AND: result = a & b;
      MLU_OR:  result = a | b;
      MLU_XOR: result = a ^ b;
      default: result = a;
    endcase
  end

  assign zero     = (result == '0);
  assign negative = result[WORD_W-1];

endmodule

/* source/register_file.sv */
`timescale 1ns/10ps

module register_file import kpu_pkg::*; (
  input  logic     clk,
  input  logic     rst,
  input  reg_sel_e reg_sel,
  input  reg_idx_t src0,
  input  reg_idx_t src1,
  input  reg_idx_t src2,
  input  reg_idx_t ctrl_idx,
  input  logic     we,
  input  word_t    wdata,
  output word_t    rdata
);

  word_t    regs [NUM_REGS];
  reg_idx_t idx;

  // Index comes from the opword fields or from microcode
  always_comb begin
    case (reg_sel)
      SEL_SRC0: idx = src0;
      SEL_SRC1: idx = src1;
      SEL_SRC2: idx = src2;
      default:  idx = ctrl_idx;
    endcase
  end

  assign rdata = regs[idx];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we) begin
      regs[idx] <= wdata;
    end
  end

endmodule

/* source/kpu_pkg.sv */
package kpu_pkg;

  localparam int WORD_W      = 32;
  localparam int REG_IDX_W   = 5;
  localparam int NUM_REGS    = 32;
  localparam int PC_REG      = 31;
  localparam int MEM_ADDR_W  = 8;
  localparam int MEM_WORDS   = 256;
  localparam int CTRL_DATA_W = 8;

  // Opword layout, immediate shares bits with src2
  localparam int OPCODE_LSB = 0;
  localparam int OPCODE_W   = 6;
  localparam int SRC0_LSB   = 6;
  localparam int SRC1_LSB   = 11;
  localparam int SRC2_LSB   = 16;
  localparam int IMM_LSB    = 16;
  localparam int IMM_W      = 16;

  typedef logic [WORD_W-1:0]    word_t;
  typedef logic [REG_IDX_W-1:0] reg_idx_t;

  // Code zero halts, so a blank memory stops the core
  typedef enum logic [OPCODE_W-1:0] {
    OP_HALT = 6'h00,
    OP_ADD  = 6'h01,
    OP_SUB  = 6'h02,
    OP_AND  = 6'h03,
    OP_OR   = 6'h04,
    OP_XOR  = 6'h05,
    OP_SHL  = 6'h06,
    OP_SHR  = 6'h07,
    OP_SAR  = 6'h08,
    OP_LDI  = 6'h09,
    OP_LD   = 6'h0a,
    OP_ST   = 6'h0b,
    OP_OUT  = 6'h0c,
    OP_TIME = 6'h0d,
    OP_JZ   = 6'h0e
  } opcode_e;

  typedef enum logic [2:0] {
    MLU_ADD, MLU_SUB, MLU_AND, MLU_OR, MLU_XOR, MLU_PASS_A
  } mlu_op_e;

  typedef enum logic [1:0] {SH_LEFT, SH_RIGHT, SH_ARITH} shift_op_e;

  typedef enum logic [1:0] {SEL_SRC0, SEL_SRC1, SEL_SRC2, SEL_CTRL} reg_sel_e;

  // Out plane
  typedef enum logic [3:0] {
    SRC_NONE, SRC_REG, SRC_TMP0, SRC_TMP1, SRC_MLU,
    SRC_SHIFTER, SRC_TIMER, SRC_MEM, SRC_CTRL_DATA, SRC_IMM
  } bus_src_e;

  // In plane
  typedef enum logic [2:0] {
    DST_NONE, DST_REG, DST_TMP0, DST_TMP1, DST_MEM, DST_OPWORD
  } bus_dst_e;

endpackage
